//--- core_pkg.sv
package core_pkg;

  // ------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;
  localparam int SHAMT_W    = 5;

  // ------------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------------
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;

  // {funct7[5], funct3}.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // ------------------------------------------------------------------
  // stage payloads
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fetch_t;

  typedef struct packed {
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rd;
    logic                  illegal;
  } issue_t;

  // illegal records carry rd only for reporting.
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic                  illegal;
  } wb_t;

endpackage

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // free slot, or the held item leaves this cycle.
  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  // upstream must hold an offered item until it is taken.
  a_hold_steady: assert property (
    @(posedge clk) disable iff (rst)
    (in_valid_i && !in_ready_o) |=> (in_valid_i && $stable(in_data_i))
  ) else $error("pipe_reg: input changed while stalled");

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                             clk,
  input  logic                             rst,

  input  logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
  input  logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
  output logic [core_pkg::XLEN-1:0]        rs1_data_o,
  output logic [core_pkg::XLEN-1:0]        rs2_data_o,
  output logic                             rs1_busy_o,
  output logic                             rs2_busy_o,

  input  logic                             set_busy_i,
  input  logic [core_pkg::REG_ADDR_W-1:0]  set_addr_i,

  input  logic                             wr_en_i,
  input  logic [core_pkg::REG_ADDR_W-1:0]  wr_addr_i,
  input  logic [core_pkg::XLEN-1:0]        wr_data_i
);

  logic [core_pkg::XLEN-1:0]     regs [core_pkg::NUM_REGS];
  logic [core_pkg::NUM_REGS-1:0] busy_q;
  logic                          wr_live;

  assign wr_live = wr_en_i && (wr_addr_i != '0);

  always_ff @(posedge clk) begin
    if (wr_live) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // set after clear, so a new owner of rd keeps the bit.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (wr_live) begin
        busy_q[wr_addr_i] <= 1'b0;
      end
      if (set_busy_i && (set_addr_i != '0)) begin
        busy_q[set_addr_i] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // write-first read ports
  // ------------------------------------------------------------------
  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (wr_live && (wr_addr_i == rs1_addr_i)) begin
      rs1_data_o = wr_data_i;
    end else begin
      rs1_data_o = regs[rs1_addr_i];
    end
    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (wr_live && (wr_addr_i == rs2_addr_i)) begin
      rs2_data_o = wr_data_i;
    end else begin
      rs2_data_o = regs[rs2_addr_i];
    end
  end

  assign rs1_busy_o = busy_q[rs1_addr_i] && !(wr_live && (wr_addr_i == rs1_addr_i));
  assign rs2_busy_o = busy_q[rs2_addr_i] && !(wr_live && (wr_addr_i == rs2_addr_i));

  a_no_set_x0: assert property (
    @(posedge clk) disable iff (rst)
    set_busy_i |-> (set_addr_i != '0)
  ) else $error("reg_file: busy set for x0");

  // every writeback must land on a register that decode marked.
  a_write_was_busy: assert property (
    @(posedge clk) disable iff (rst)
    wr_live |-> busy_q[wr_addr_i]
  ) else $error("reg_file: write to register that was not busy");

endmodule

//--- inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  core_pkg::fetch_t                 in_data_i,

  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output core_pkg::issue_t                 out_data_o,

  output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
  output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
  input  logic [core_pkg::XLEN-1:0]        rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]        rs2_data_i,
  input  logic                             rs1_busy_i,
  input  logic                             rs2_busy_i,

  output logic                             set_busy_o,
  output logic [core_pkg::REG_ADDR_W-1:0]  set_addr_o
);

  logic [core_pkg::INST_W-1:0]     inst;
  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [core_pkg::REG_ADDR_W-1:0] rd;
  logic [core_pkg::XLEN-1:0]       imm_i;
  logic [core_pkg::XLEN-1:0]       imm_u;
  logic                            use_rs1;
  logic                            use_rs2;
  logic                            stall;

  // ------------------------------------------------------------------
  // fields and immediates
  // ------------------------------------------------------------------
  assign inst   = in_data_i.inst;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_u  = {inst[31:12], 12'b0};

  assign rs1_addr_o = inst[19:15];
  assign rs2_addr_o = inst[24:20];

  always_comb begin
    use_rs1            = 1'b0;
    use_rs2            = 1'b0;
    out_data_o.op1     = '0;
    out_data_o.op2     = '0;
    out_data_o.alu_op  = core_pkg::ALU_ADD;
    out_data_o.rd      = rd;
    out_data_o.illegal = 1'b0;
    case (opcode)
      core_pkg::OP_LUI: begin
        out_data_o.op2 = imm_u;
      end
      core_pkg::OP_AUIPC: begin
        out_data_o.op1 = in_data_i.pc;
        out_data_o.op2 = imm_u;
      end
      core_pkg::OP_IMM: begin
        use_rs1           = 1'b1;
        out_data_o.op1    = rs1_data_i;
        out_data_o.op2    = imm_i;
        // only srai carries funct7[5] into the op.
        out_data_o.alu_op = core_pkg::alu_op_e'({(funct3 == 3'b101) && funct7[5], funct3});
        if (funct3 == 3'b001) begin
          out_data_o.illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          out_data_o.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      core_pkg::OP_REG: begin
        use_rs1           = 1'b1;
        use_rs2           = 1'b1;
        out_data_o.op1    = rs1_data_i;
        out_data_o.op2    = rs2_data_i;
        out_data_o.alu_op = core_pkg::alu_op_e'({funct7[5], funct3});
        if (funct7 == 7'h20) begin
          out_data_o.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          out_data_o.illegal = (funct7 != 7'h00);
        end
      end
      default: begin
        out_data_o.illegal = 1'b1;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // hazard stall and issue
  // ------------------------------------------------------------------
  assign stall = in_valid_i && ((use_rs1 && rs1_busy_i) || (use_rs2 && rs2_busy_i));

  assign out_valid_o = in_valid_i && !stall;
  assign in_ready_o  = out_ready_i && !stall;

  // x0 and illegal ops never own a register.
  assign set_busy_o = out_valid_o && out_ready_i && !out_data_o.illegal && (rd != '0);
  assign set_addr_o = rd;

endmodule

//--- int_alu.sv
`timescale 1ns/1ps

module int_alu (
  input  core_pkg::issue_t in_data_i,
  output core_pkg::wb_t    out_data_o
);

  logic [core_pkg::XLEN-1:0]    op1;
  logic [core_pkg::XLEN-1:0]    op2;
  logic [core_pkg::SHAMT_W-1:0] shamt;
  logic [core_pkg::XLEN-1:0]    result;

  assign op1   = in_data_i.op1;
  assign op2   = in_data_i.op2;
  assign shamt = op2[core_pkg::SHAMT_W-1:0];

  always_comb begin
    case (in_data_i.alu_op)
      core_pkg::ALU_ADD: begin
        result = op1 + op2;
      end
      core_pkg::ALU_SUB: begin
        result = op1 - op2;
      end
      core_pkg::ALU_SLL: begin
        result = op1 << shamt;
      end
      core_pkg::ALU_SLT: begin
        result = {{(core_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      end
      core_pkg::ALU_SLTU: begin
        result = {{(core_pkg::XLEN-1){1'b0}}, op1 < op2};
      end
      core_pkg::ALU_XOR: begin
        result = op1 ^ op2;
      end
      core_pkg::ALU_SRL: begin
        result = op1 >> shamt;
      end
      core_pkg::ALU_SRA: begin
        result = $unsigned($signed(op1) >>> shamt);
      end
      core_pkg::ALU_OR: begin
        result = op1 | op2;
      end
      core_pkg::ALU_AND: begin
        result = op1 & op2;
      end
      // unused codes only come with illegal set.
      default: begin
        result = '0;
      end
    endcase
  end

  assign out_data_o.rd      = in_data_i.rd;
  assign out_data_o.data    = result;
  assign out_data_o.illegal = in_data_i.illegal;

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic             clk,
  input  logic             rst,

  input  logic             inst_valid_i,
  output logic             inst_ready_o,
  input  core_pkg::fetch_t inst_i,

  output logic             wb_valid_o,
  output core_pkg::wb_t    wb_o
);

  logic                            fetch_valid;
  logic                            fetch_ready;
  core_pkg::fetch_t                fetch_data;
  logic                            dec_valid;
  logic                            dec_ready;
  core_pkg::issue_t                dec_data;
  logic                            iss_valid;
  logic                            iss_ready;
  core_pkg::issue_t                iss_data;
  core_pkg::wb_t                   alu_data;
  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [core_pkg::XLEN-1:0]       rs1_data;
  logic [core_pkg::XLEN-1:0]       rs2_data;
  logic                            rs1_busy;
  logic                            rs2_busy;
  logic                            set_busy;
  logic [core_pkg::REG_ADDR_W-1:0] set_addr;
  logic                            superseded;
  logic                            wr_en;

  // accepted at edge n, the record is seen at edge n+3 with no stall.
  pipe_reg #(.payload_t(core_pkg::fetch_t)) fetch_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(inst_valid_i), .in_ready_o(inst_ready_o), .in_data_i(inst_i),
    .out_valid_o(fetch_valid), .out_ready_i(fetch_ready), .out_data_o(fetch_data)
  );

  inst_decode u_decode (
    .in_valid_i(fetch_valid), .in_ready_o(fetch_ready), .in_data_i(fetch_data),
    .out_valid_o(dec_valid), .out_ready_i(dec_ready), .out_data_o(dec_data),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rs1_busy_i(rs1_busy), .rs2_busy_i(rs2_busy),
    .set_busy_o(set_busy), .set_addr_o(set_addr)
  );

  pipe_reg #(.payload_t(core_pkg::issue_t)) issue_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(dec_valid), .in_ready_o(dec_ready), .in_data_i(dec_data),
    .out_valid_o(iss_valid), .out_ready_i(iss_ready), .out_data_o(iss_data)
  );

  int_alu u_alu (
    .in_data_i(iss_data),
    .out_data_o(alu_data)
  );

  pipe_reg #(.payload_t(core_pkg::wb_t)) wb_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(iss_valid), .in_ready_o(iss_ready), .in_data_i(alu_data),
    .out_valid_o(wb_valid_o), .out_ready_i(1'b1), .out_data_o(wb_o)
  );

  // ------------------------------------------------------------------
  // writeback to the register file
  // ------------------------------------------------------------------
  // a younger write to the same rd in the issue buffer still owns the
  // busy bit. dropping this write keeps the bit set until that one lands.
  assign superseded = iss_valid && !iss_data.illegal && (iss_data.rd == wb_o.rd);
  assign wr_en      = wb_valid_o && !wb_o.illegal && (wb_o.rd != '0) && !superseded;

  reg_file u_rf (
    .clk(clk), .rst(rst),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .rs1_busy_o(rs1_busy), .rs2_busy_o(rs2_busy),
    .set_busy_i(set_busy), .set_addr_i(set_addr),
    .wr_en_i(wr_en), .wr_addr_i(wb_o.rd), .wr_data_i(wb_o.data)
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // released on a falling edge, clear of the sampling edge.
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- core_tb.sv
`timescale 1ns/1ps

module core_tb;

  localparam int TOTAL_INSTS     = 87;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTS * 20 + 100;

  logic             clk;
  logic             rst;
  logic             inst_valid_i;
  logic             inst_ready_o;
  core_pkg::fetch_t inst_i;
  logic             wb_valid_o;
  core_pkg::wb_t    wb_o;

  core_pkg::wb_t    exp_q[$];
  core_pkg::wb_t    got_q[$];
  logic [31:0]      model_regs [32];
  logic [31:0]      next_pc;
  int               seed = 16;
  int               errors = 0;
  int               checks = 0;
  int               err_base = 0;
  int               tests_run = 0;

  tb_clock_gen #(.PERIOD_NS(4), .RST_CYCLES(5)) clk_gen (.clk(clk), .rst(rst));

  core_top DUT (
    .clk(clk), .rst(rst),
    .inst_valid_i(inst_valid_i), .inst_ready_o(inst_ready_o), .inst_i(inst_i),
    .wb_valid_o(wb_valid_o), .wb_o(wb_o)
  );

  // ------------------------------------------------------------------
  // encoders and reference model
  // ------------------------------------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, core_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, core_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                        input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  // rv32i integer semantics, alt selects sub and sra.
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic predict(input logic [31:0] inst, input logic [31:0] pc);
    logic [6:0]    f7;
    logic [2:0]    f3;
    logic [31:0]   a;
    logic [31:0]   b;
    core_pkg::wb_t r;
    f7 = inst[31:25];
    f3 = inst[14:12];
    a  = model_regs[inst[19:15]];
    b  = model_regs[inst[24:20]];
    r.rd      = inst[11:7];
    r.data    = '0;
    r.illegal = 1'b0;
    case (inst[6:0])
      core_pkg::OP_LUI: r.data = {inst[31:12], 12'h000};
      core_pkg::OP_AUIPC: r.data = pc + {inst[31:12], 12'h000};
      core_pkg::OP_IMM: begin
        b = {{20{inst[31]}}, inst[31:20]};
        if (f3 == 3'd1) begin
          r.illegal = (f7 != 7'h00);
        end else if (f3 == 3'd5) begin
          r.illegal = (f7 != 7'h00) && (f7 != 7'h20);
        end
        r.data = alu_ref(f3, (f3 == 3'd5) && f7[5], a, b);
      end
      core_pkg::OP_REG: begin
        r.illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5)));
        r.data    = alu_ref(f3, f7[5], a, b);
      end
      default: r.illegal = 1'b1;
    endcase
    if (!r.illegal && r.rd != 5'd0) begin
      model_regs[r.rd] = r.data;
    end
    exp_q.push_back(r);
  endtask

  // ------------------------------------------------------------------
  // drive, collect, check
  // ------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("[FAIL] %s exp=%h got=%h", name, exp, got);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic run_inst(input logic [31:0] inst);
    predict(inst, next_pc);
    inst_valid_i = 1'b1;
    inst_i.inst  = inst;
    inst_i.pc    = next_pc;
    next_pc      = next_pc + 32'd4;
    while (!inst_ready_o) @(negedge clk);
    @(negedge clk);
    inst_valid_i = 1'b0;
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = (v + 32'h800) >> 12;
    run_inst(enc_u(core_pkg::OP_LUI, upper[19:0], rd));
    run_inst(enc_i(v[11:0], rd, 3'd0, rd));
    // the addi record carries the full value.
    while (got_q.size() < exp_q.size()) @(negedge clk);
    check_val($sformatf("wb_o.data x%0d", rd), v, got_q[got_q.size() - 1].data);
  endtask

  always @(negedge clk) begin
    if (!rst && wb_valid_o) begin
      got_q.push_back(wb_o);
    end
  end

  task automatic finish_test(input string name);
    core_pkg::wb_t exp_r;
    core_pkg::wb_t got_r;
    int            n;
    while (got_q.size() < exp_q.size()) @(negedge clk);
    repeat (4) @(negedge clk);
    n = exp_q.size();
    check_val("record count", n, got_q.size());
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      exp_r = exp_q.pop_front();
      got_r = got_q.pop_front();
      check_val("wb_o.illegal", exp_r.illegal, got_r.illegal);
      check_val("wb_o.rd", exp_r.rd, got_r.rd);
      if (!exp_r.illegal) begin
        check_val("wb_o.data", exp_r.data, got_r.data);
      end
    end
    exp_q.delete();
    got_q.delete();
    tests_run++;
    $display("test %-10s done: %0d records, %0d errors", name, n, errors - err_base);
    err_base = errors;
  endtask

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------
  task automatic test_reset_load();
    check_val("inst_ready_o", 1, inst_ready_o);
    check_val("wb_valid_o", 0, wb_valid_o);
    load_reg(5'd1, 32'h1234_5678);
    load_reg(5'd2, 32'hFFFF_F800);
    load_reg(5'd3, 32'h0000_0FFF);
    load_reg(5'd4, 32'h8000_0000);
    run_inst(enc_u(core_pkg::OP_LUI, 20'hABCDE, 5'd5));
    finish_test("reset_load");
  endtask

  task automatic test_auipc();
    next_pc = 32'h0000_1000;
    run_inst(enc_u(core_pkg::OP_AUIPC, 20'h00012, 5'd6));
    next_pc = 32'h8000_0004;
    run_inst(enc_u(core_pkg::OP_AUIPC, 20'hFFFFF, 5'd7));
    finish_test("auipc");
  endtask

  task automatic test_alu_ops();
    logic [11:0] imm;
    logic [2:0]  f3;
    int          round;
    int          k;
    for (round = 0; round < 2; round++) begin
      load_reg(5'd8, $random(seed));
      load_reg(5'd9, $random(seed));
      // eight base ops, then sub and sra.
      for (k = 0; k < 10; k++) begin
        f3 = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
        run_inst(enc_r((k < 8) ? 7'h00 : 7'h20, 5'd9, 5'd8, f3, 5'(10 + k)));
      end
      for (k = 0; k < 8; k++) begin
        imm = $random(seed);
        if (k == 1 || k == 5) begin
          imm[11:5] = 7'h00;
        end
        run_inst(enc_i(imm, 5'd8, k[2:0], 5'(20 + k)));
      end
      imm = {7'h20, 5'($random(seed))};
      run_inst(enc_i(imm, 5'd8, 3'd5, 5'd28));
    end
    finish_test("alu_ops");
  endtask

  task automatic test_dep_chain();
    int i;
    run_inst(enc_i(12'd7, 5'd0, 3'd0, 5'd3));
    for (i = 0; i < 8; i++) begin
      run_inst(enc_r(7'h00, 5'd3, 5'd3, 3'd0, 5'd4));
      run_inst(enc_i(12'(i * 37 + 5), 5'd4, 3'd4, 5'd3));
    end
    // two writes to x5 in flight, then a reader.
    run_inst(enc_i(12'd11, 5'd0, 3'd0, 5'd5));
    run_inst(enc_i(12'd22, 5'd0, 3'd0, 5'd5));
    run_inst(enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
    finish_test("dep_chain");
  endtask

  task automatic test_illegal_x0();
    run_inst(enc_i(12'h123, 5'd0, 3'd0, 5'd7));
    run_inst({12'h000, 5'd0, 3'd2, 5'd7, 7'b0000011});
    run_inst({20'h00000, 5'd7, 7'b1101111});
    run_inst(enc_i({7'h20, 5'd3}, 5'd7, 3'd1, 5'd7));
    run_inst(enc_r(7'h01, 5'd7, 5'd7, 3'd0, 5'd7));
    run_inst(enc_r(7'h00, 5'd0, 5'd7, 3'd0, 5'd8));
    run_inst(enc_i(12'd55, 5'd0, 3'd0, 5'd0));
    run_inst(enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd0));
    run_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
    finish_test("illegal_x0");
  endtask

  task automatic test_latency();
    logic [31:0] inst;
    int          edges;
    inst = enc_i(12'd9, 5'd0, 3'd0, 5'd12);
    predict(inst, next_pc);
    check_val("inst_ready_o", 1, inst_ready_o);
    inst_valid_i = 1'b1;
    inst_i.inst  = inst;
    inst_i.pc    = next_pc;
    next_pc      = next_pc + 32'd4;
    @(negedge clk);
    inst_valid_i = 1'b0;
    edges = 1;
    while (!wb_valid_o && edges < 10) begin
      @(negedge clk);
      edges++;
    end
    check_val("wb_valid_o latency", 3, edges);
    finish_test("latency");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: pipeline did not finish the tests in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    inst_valid_i = 1'b0;
    inst_i       = '0;
    next_pc      = 32'h0000_0100;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    @(negedge clk);
    while (rst) @(negedge clk);
    test_reset_load();
    test_auipc();
    test_alu_ops();
    test_dep_chain();
    test_illegal_x0();
    test_latency();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
core_pkg.sv
pipe_reg.sv
reg_file.sv
inst_decode.sv
int_alu.sv
core_top.sv
tb_clock_gen.sv
core_tb.sv
